//--- tb/spi_master_tests.txt
# div len opt tx0..tx7 rsp0..rsp7, all hex; len counts the bytes used from each row
# opt bit 0 sends a second start while busy, opt bit 1 writes one TXD byte too many
00 1 0 a5 00 00 00 00 00 00 00 5a 00 00 00 00 00 00 00
03 1 0 3c 00 00 00 00 00 00 00 c3 00 00 00 00 00 00 00
14 1 0 81 00 00 00 00 00 00 00 7e 00 00 00 00 00 00 00
00 8 0 01 23 45 67 89 ab cd ef fe dc ba 98 76 54 32 10
03 8 0 11 22 44 88 f0 0f aa 55 ff 00 80 01 7f fe 69 96
14 8 0 de ad be ef 12 34 56 78 87 65 43 21 fe ed fa ce
02 3 0 10 20 30 00 00 00 00 00 e1 d2 c3 00 00 00 00 00
01 5 1 9a 8b 7c 6d 5e 00 00 00 13 57 9b df 02 00 00 00
03 8 2 b1 b2 b3 b4 b5 b6 b7 b8 c1 c2 c3 c4 c5 c6 c7 c8
00 8 3 0f 1e 2d 3c 4b 5a 69 78 87 96 a5 b4 c3 d2 e1 f0
05 2 1 ff 00 00 00 00 00 00 00 00 ff 00 00 00 00 00 00

//--- spi_master_top.f
+incdir+rtl
rtl/spi_master_pkg.sv
rtl/spi_byte_engine.sv
rtl/spi_frame_sequencer.sv
rtl/spi_ctrl_regs.sv
rtl/spi_master_top.sv
tb/spi_slave_model.sv
tb/spi_master_properties.sv
tb/tb_spi_master_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_spi_master_top
FILELIST  ?= spi_master_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/tb_spi_master_top.sv
`default_nettype none
`timescale 1ns/1ns

`include "spi_master_params.svh"

module tb_spi_master_top;
  import spi_master_pkg::*;

  localparam int POLL_LIMIT = 5000;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   wr_en;
  logic                   rd_en;
  logic [`SPI_ADDR_W-1:0] addr;
  logic [7:0]             wr_data;
  logic [7:0]             rd_data;
  logic                   miso;
  spi_pins_t              pins;
  spi_pins_t              pins_q;
  logic [63:0]            response;
  logic [63:0]            received;
  logic [3:0]             received_count;
  logic                   count_clr;
  int                     ss_falls = 0;
  int                     ss_rises = 0;
  int                     sclk_falls = 0;
  int                     errors = 0;
  int                     test_errors;
  int                     tests_run = 0;
  int                     tests_failed = 0;
  logic                   timed_out = 1'b0;

  always #50 clk = ~clk;

  spi_master_top spi_master_top_i (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .rd_en   (rd_en),
    .addr    (addr),
    .wr_data (wr_data),
    .rd_data (rd_data),
    .miso    (miso),
    .pins    (pins)
  );

  spi_slave_model spi_slave_model_i (
    .sclk           (pins.sclk),
    .mosi           (pins.mosi),
    .ss_n           (pins.ss_n),
    .response       (response),
    .miso           (miso),
    .received       (received),
    .received_count (received_count)
  );

  // Count the edges on the SPI pins over each frame.
  always @(posedge clk)
  begin
    pins_q <= pins;
    if (count_clr)
    begin
      ss_falls   <= 0;
      ss_rises   <= 0;
      sclk_falls <= 0;
    end
    else
    begin
      if (pins_q.ss_n && !pins.ss_n)
        ss_falls <= ss_falls + 1;
      if (!pins_q.ss_n && pins.ss_n)
        ss_rises <= ss_rises + 1;
      if (pins_q.sclk && !pins.sclk)
        sclk_falls <= sclk_falls + 1;
    end
  end

  task automatic write_reg(input spi_reg_addr_e a, input logic [7:0] d);
    @(posedge clk);
    wr_en   <= 1'b1;
    addr    <= a;
    wr_data <= d;
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  task automatic read_reg(input spi_reg_addr_e a, output logic [7:0] d);
    @(posedge clk);
    rd_en <= 1'b1;
    addr  <= a;
    @(posedge clk);
    rd_en <= 1'b0;
    @(negedge clk);
    d = rd_data;
  endtask

  task automatic wait_done(output logic ok);
    logic [7:0] st;
    int         polls;
    ok    = 1'b0;
    polls = 0;
    while (!ok && polls < POLL_LIMIT)
    begin
      read_reg(STATUS, st);
      ok = st[1];
      polls++;
    end
  endtask

  task automatic report_mismatch(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  initial
  begin
    int         fd;
    int         n;
    int         div;
    int         len;
    int         opt;
    int         writes;
    int         exp_cnt;
    int         tx [8];
    int         rsp [8];
    string      line;
    logic [7:0] st;
    logic [7:0] rx;
    logic       ok;

    rst       = 1'b1;
    wr_en     = 1'b0;
    rd_en     = 1'b0;
    addr      = '0;
    wr_data   = '0;
    count_clr = 1'b1;
    response  = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    test_errors = 0;
    read_reg(STATUS, st);
    if (st != 8'h00)
      report_mismatch($sformatf("STATUS after reset is %02h, expected 00", st));
    if (!pins.ss_n || !pins.sclk)
      report_mismatch("ss_n or sclk not high after reset");
    tests_run++;
    if (test_errors != 0)
      tests_failed++;
    $display("test 0 reset: %s", test_errors == 0 ? "ok" : "failed");

    fd = $fopen("tb/spi_master_tests.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the test file tb/spi_master_tests.txt");
      errors++;
    end
    while (fd != 0 && !timed_out && $fgets(line, fd) != 0)
    begin
      if (line.len() == 0 || line[0] == "#")
        continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  div, len, opt, tx[0], tx[1], tx[2], tx[3], tx[4], tx[5], tx[6], tx[7],
                  rsp[0], rsp[1], rsp[2], rsp[3], rsp[4], rsp[5], rsp[6], rsp[7]);
      if (n != 19)
        continue;
      test_errors = 0;
      tests_run++;
      for (int i = 0; i < 8; i++)
        response[8*i +: 8] <= rsp[i][7:0];
      write_reg(DIV, div[7:0]);
      write_reg(LEN, len[7:0]);
      // Option bit 1 pushes one byte past the buffer, which must be dropped.
      writes = len + (opt[1] ? 1 : 0);
      for (int i = 0; i < writes; i++)
        write_reg(TXD, i < 8 ? tx[i][7:0] : 8'hc3);
      exp_cnt = writes > 8 ? 8 : writes;
      read_reg(STATUS, st);
      if (int'(st[7:4]) != exp_cnt || st[0])
        report_mismatch($sformatf("STATUS before start is %02h, count %0d expected", st,
                                  exp_cnt));
      @(posedge clk);
      count_clr <= 1'b1;
      @(posedge clk);
      count_clr <= 1'b0;
      write_reg(CTRL, 8'h01);
      // Option bit 0 issues a second start while the frame is running.
      if (opt[0])
        write_reg(CTRL, 8'h01);
      // A frame lasts far longer than this read, so the frame is still running.
      read_reg(STATUS, st);
      if (!st[0] || st[1])
        report_mismatch($sformatf("STATUS after start is %02h, expected busy and not done",
                                  st));
      wait_done(ok);
      if (!ok)
      begin
        $display("Timeout: STATUS never reported done in test %0d", tests_run - 1);
        timed_out = 1'b1;
        errors++;
        test_errors++;
      end
      else
      begin
        if (int'(received_count) != len)
          report_mismatch($sformatf("slave got %0d bytes, expected %0d", received_count, len));
        for (int i = 0; i < len; i++)
          if (received[8*i +: 8] != tx[i][7:0])
            report_mismatch($sformatf("slave byte %0d is %02h, expected %02h", i,
                                      received[8*i +: 8], tx[i][7:0]));
        if (sclk_falls != 8 * len)
          report_mismatch($sformatf("%0d sclk falling edges, expected %0d", sclk_falls,
                                    8 * len));
        if (ss_falls != 1 || ss_rises != 1)
          report_mismatch($sformatf("ss_n fell %0d and rose %0d times", ss_falls, ss_rises));
        for (int i = 0; i < len; i++)
        begin
          read_reg(RXD, rx);
          if (rx != rsp[i][7:0])
            report_mismatch($sformatf("RXD byte %0d is %02h, expected %02h", i, rx,
                                      rsp[i][7:0]));
        end
        read_reg(RXD, rx);
        if (rx != 8'h00)
          report_mismatch($sformatf("RXD past the frame is %02h, expected 00", rx));
      end
      if (test_errors != 0)
        tests_failed++;
      $display("test %0d div=%0d len=%0d opt=%0d: %s", tests_run - 1, div, len, opt,
               test_errors == 0 ? "ok" : "failed");
    end
    if (fd != 0)
      $fclose(fd);

    $display("%0d tests, %0d passed, %0d failed, %0d assertion failures", tests_run,
             tests_run - tests_failed, tests_failed,
             spi_master_top_i.spi_master_properties_i.violations);
    if (errors == 0 && !timed_out && tests_run > 1
        && spi_master_top_i.spi_master_properties_i.violations == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/spi_master_properties.sv
`default_nettype none
`timescale 1ns/1ns

module spi_master_properties (
  input logic                              clk,
  input logic                              rst,
  input spi_master_pkg::spi_pins_t         pins,
  input spi_master_pkg::spi_frame_status_t frame_status,
  input logic                              begin_transmission,
  input logic                              end_transmission
);

  int unsigned violations = 0;

  ss_high_when_idle: assert property (@(posedge clk) disable iff (rst)
    !frame_status.busy |-> pins.ss_n)
    else begin $error("slave select low while the sequencer is idle"); violations++; end

  sclk_quiet_when_deselected: assert property (@(posedge clk) disable iff (rst)
    pins.ss_n && $past(pins.ss_n) |-> $stable(pins.sclk))
    else begin $error("sclk toggled while slave select is high"); violations++; end

  begin_end_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(begin_transmission && end_transmission))
    else begin $error("begin and end of a byte in the same cycle"); violations++; end

  // The slave samples on the rising edge, so data must hold through the high phase.
  mosi_stable_sclk_high: assert property (@(posedge clk) disable iff (rst)
    pins.sclk && $past(pins.sclk) && !pins.ss_n |-> $stable(pins.mosi))
    else begin $error("mosi changed while sclk is high"); violations++; end

endmodule

bind spi_master_top spi_master_properties spi_master_properties_i (
  .clk                (clk),
  .rst                (rst),
  .pins               (pins),
  .frame_status       (frame_status),
  .begin_transmission (begin_transmission),
  .end_transmission   (end_transmission)
);

`default_nettype wire

//--- tb/spi_slave_model.sv
`default_nettype none
`timescale 1ns/1ns

module spi_slave_model (
  input  logic        sclk,
  input  logic        mosi,
  input  logic        ss_n,
  input  logic [63:0] response,
  output logic        miso,
  output logic [63:0] received,
  output logic [3:0]  received_count
);

  logic       sclk_q = 1'b1;
  logic       ss_q = 1'b1;
  logic [6:0] rise_count = '0;
  logic [7:0] rx_shift = '0;

  initial miso = 1'b1;

  // Response byte i sits at bits 8*i+7 down to 8*i, and goes out most significant bit first.
  function automatic logic response_bit(input logic [6:0] rc);
    int idx;
    idx = 8 * int'(rc[5:3]) + 7 - int'(rc[2:0]);
    return response[idx];
  endfunction

  always @(sclk or ss_n)
  begin
    if (ss_q && !ss_n)
    begin
      rise_count     = '0;
      received_count = '0;
      miso          <= response_bit(7'd0);
    end
    else if (!ss_n && !sclk_q && sclk)
    begin
      rx_shift   = {rx_shift[6:0], mosi};
      rise_count = rise_count + 7'd1;
      if (rise_count[2:0] == 3'd0)
      begin
        received[8 * int'(received_count) +: 8] = rx_shift;
        received_count = received_count + 4'd1;
      end
    end
    else if (!ss_n && sclk_q && !sclk)
      miso <= response_bit(rise_count);
    sclk_q = sclk;
    ss_q   = ss_n;
  end

endmodule

`default_nettype wire

//--- rtl/spi_master_top.sv
`default_nettype none
`timescale 1ns/1ns

`include "spi_master_params.svh"

module spi_master_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      wr_en,
  input  logic                      rd_en,
  input  logic [`SPI_ADDR_W-1:0]    addr,
  input  logic [7:0]                wr_data,
  output logic [7:0]                rd_data,
  input  logic                      miso,
  output spi_master_pkg::spi_pins_t pins
);
  import spi_master_pkg::*;

  spi_cfg_t          cfg;
  spi_frame_status_t frame_status;
  logic              start;
  logic [2:0]        tx_index;
  logic [7:0]        tx_byte;
  logic              rx_we;
  logic [2:0]        rx_index;
  logic [7:0]        rx_byte;
  logic              ss_n;
  logic [7:0]        send_data;
  logic              begin_transmission;
  logic [7:0]        received_data;
  logic              end_transmission;
  logic              mosi;
  logic              sclk;

  spi_ctrl_regs spi_ctrl_regs_i (
    .clk          (clk),
    .rst          (rst),
    .wr_en        (wr_en),
    .rd_en        (rd_en),
    .addr         (addr),
    .wr_data      (wr_data),
    .rd_data      (rd_data),
    .cfg          (cfg),
    .start        (start),
    .tx_index     (tx_index),
    .tx_byte      (tx_byte),
    .rx_we        (rx_we),
    .rx_index     (rx_index),
    .rx_byte      (rx_byte),
    .frame_status (frame_status)
  );

  spi_frame_sequencer spi_frame_sequencer_i (
    .clk                (clk),
    .rst                (rst),
    .start              (start),
    .cfg                (cfg),
    .tx_index           (tx_index),
    .tx_byte            (tx_byte),
    .rx_we              (rx_we),
    .rx_index           (rx_index),
    .rx_byte            (rx_byte),
    .frame_status       (frame_status),
    .ss_n               (ss_n),
    .send_data          (send_data),
    .begin_transmission (begin_transmission),
    .received_data      (received_data),
    .end_transmission   (end_transmission)
  );

  spi_byte_engine spi_byte_engine_i (
    .clk                (clk),
    .rst                (rst),
    .div                (cfg.div),
    .send_data          (send_data),
    .begin_transmission (begin_transmission),
    .slave_select       (ss_n),
    .miso               (miso),
    .received_data      (received_data),
    .end_transmission   (end_transmission),
    .mosi               (mosi),
    .sclk               (sclk)
  );

  assign pins = '{sclk: sclk, mosi: mosi, ss_n: ss_n};

endmodule

`default_nettype wire

//--- rtl/spi_ctrl_regs.sv
`default_nettype none
`timescale 1ns/1ns

`include "spi_master_params.svh"

module spi_ctrl_regs (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              wr_en,
  input  logic                              rd_en,
  input  logic [`SPI_ADDR_W-1:0]            addr,
  input  logic [7:0]                        wr_data,
  output logic [7:0]                        rd_data,
  output spi_master_pkg::spi_cfg_t          cfg,
  output logic                              start,
  input  logic [2:0]                        tx_index,
  output logic [7:0]                        tx_byte,
  input  logic                              rx_we,
  input  logic [2:0]                        rx_index,
  input  logic [7:0]                        rx_byte,
  input  spi_master_pkg::spi_frame_status_t frame_status
);
  import spi_master_pkg::*;

  spi_byte_t            tx_buf [`SPI_BUF_DEPTH];
  spi_byte_t            rx_buf [`SPI_BUF_DEPTH];
  logic [SPI_CNT_W-1:0] tx_count;
  logic [SPI_CNT_W-1:0] rx_fill;
  logic [SPI_CNT_W-1:0] rx_ptr;
  logic                 done;
  logic                 start_req;
  logic                 tx_accept;
  logic                 rx_avail;
  spi_reg_addr_e        reg_sel;

  assign reg_sel   = spi_reg_addr_e'(addr);
  assign start_req = wr_en && reg_sel == CTRL && wr_data[0];
  assign tx_accept = wr_en && reg_sel == TXD && tx_count < SPI_CNT_W'(`SPI_BUF_DEPTH);
  assign rx_avail  = rx_ptr < rx_fill;
  assign tx_byte   = tx_buf[tx_index];

  // The divider register is loaded zero-extended from the 8-bit host data.
  always_ff @(posedge clk)
  begin
    if (rst)
      cfg <= '0;
    else if (wr_en && reg_sel == DIV)
      cfg.div <= {{(`SPI_DIV_W-8){1'b0}}, wr_data};
    else if (wr_en && reg_sel == LEN)
      cfg.len <= wr_data[3:0];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      start <= 1'b0;
      done  <= 1'b0;
    end
    else
    begin
      start <= start_req;
      if (start_req)
        done <= 1'b0;
      else if (frame_status.done_pulse)
        done <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (tx_accept)
      tx_buf[tx_count[SPI_IDX_W-1:0]] <= wr_data;
    if (rx_we)
      rx_buf[rx_index] <= rx_byte;
  end

  // The transmit count empties once the frame has consumed the buffer.
  always_ff @(posedge clk)
  begin
    if (rst)
      tx_count <= '0;
    else if (frame_status.done_pulse)
      tx_count <= '0;
    else if (tx_accept)
      tx_count <= tx_count + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rx_fill <= '0;
      rx_ptr  <= '0;
    end
    else if (start_req)
    begin
      rx_fill <= '0;
      rx_ptr  <= '0;
    end
    else
    begin
      if (rx_we)
        rx_fill <= SPI_CNT_W'(rx_index) + 1'b1;
      if (rd_en && reg_sel == RXD && rx_avail)
        rx_ptr <= rx_ptr + 1'b1;
    end
  end

  // STATUS bit 7 flags a full transmit buffer, as the top bit of the count.
  always_ff @(posedge clk)
  begin
    if (rst)
      rd_data <= 8'h00;
    else if (rd_en)
    begin
      case (reg_sel)
        DIV:     rd_data <= cfg.div[7:0];
        LEN:     rd_data <= {4'b0000, cfg.len};
        RXD:     rd_data <= rx_avail ? rx_buf[rx_ptr[SPI_IDX_W-1:0]] : 8'h00;
        STATUS:  rd_data <= {tx_count, 2'b00, done, frame_status.busy};
        default: rd_data <= 8'h00;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/spi_frame_sequencer.sv
`default_nettype none
`timescale 1ns/1ns

`include "spi_master_params.svh"

module spi_frame_sequencer (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               start,
  input  spi_master_pkg::spi_cfg_t           cfg,
  output logic [2:0]                         tx_index,
  input  logic [7:0]                         tx_byte,
  output logic                               rx_we,
  output logic [2:0]                         rx_index,
  output logic [7:0]                         rx_byte,
  output spi_master_pkg::spi_frame_status_t  frame_status,
  output logic                               ss_n,
  output logic [7:0]                         send_data,
  output logic                               begin_transmission,
  input  logic [7:0]                         received_data,
  input  logic                               end_transmission
);
  import spi_master_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_SELECT,
    S_LAUNCH,
    S_WAIT,
    S_DESELECT
  } seq_state_e;

  seq_state_e           state;
  logic [2:0]           byte_cnt;
  logic [SPI_CNT_W-1:0] bytes_done;
  logic                 last_byte;

  // A length of zero sends one byte, and lengths past the buffer stop at its end.
  assign bytes_done = SPI_CNT_W'(byte_cnt) + 1'b1;
  assign last_byte  = bytes_done >= SPI_CNT_W'(cfg.len)
                   || bytes_done == SPI_CNT_W'(`SPI_BUF_DEPTH);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= S_IDLE;
      byte_cnt <= '0;
      ss_n     <= 1'b1;
    end
    else
    begin
      case (state)
        S_IDLE:
          if (start)
          begin
            state    <= S_SELECT;
            byte_cnt <= '0;
            ss_n     <= 1'b0;
          end
        S_SELECT:
          state <= S_LAUNCH;
        S_LAUNCH:
          state <= S_WAIT;
        S_WAIT:
          if (end_transmission)
          begin
            if (last_byte)
            begin
              state <= S_DESELECT;
              ss_n  <= 1'b1;
            end
            else
            begin
              state    <= S_LAUNCH;
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
        default:
          state <= S_IDLE;
      endcase
    end
  end

  assign tx_index           = byte_cnt;
  assign send_data          = tx_byte;
  assign begin_transmission = state == S_LAUNCH;

  // Each received byte lands at the index of the byte that was sent with it.
  assign rx_we    = state == S_WAIT && end_transmission;
  assign rx_index = byte_cnt;
  assign rx_byte  = received_data;

  assign frame_status.busy       = state != S_IDLE;
  assign frame_status.done_pulse = state == S_DESELECT;

endmodule

`default_nettype wire

//--- rtl/spi_byte_engine.sv
`default_nettype none
`timescale 1ns/1ns

`include "spi_master_params.svh"

module spi_byte_engine (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`SPI_DIV_W-1:0] div,
  input  logic [7:0]            send_data,
  input  logic                  begin_transmission,
  input  logic                  slave_select,
  input  logic                  miso,
  output logic [7:0]            received_data,
  output logic                  end_transmission,
  output logic                  mosi,
  output logic                  sclk
);

  typedef enum logic [1:0] {
    E_IDLE,
    E_SHIFT,
    E_HOLD
  } engine_state_e;

  engine_state_e         state;
  logic [`SPI_DIV_W-1:0] half_count;
  logic                  sclk_int;
  logic                  sclk_prev;
  logic                  sclk_fall;
  logic                  sclk_rise;
  logic                  last_rise;
  logic                  load;
  logic [2:0]            bit_count;
  logic [7:0]            shift_reg;

  // The pin follows the internal clock by one cycle, so each detected edge
  // coincides with the edge appearing on SCLK.
  assign sclk      = sclk_prev;
  assign sclk_fall = sclk_prev && !sclk_int;
  assign sclk_rise = !sclk_prev && sclk_int;
  assign last_rise = state == E_SHIFT && sclk_rise && bit_count == 3'd7;

  // A rising slave select in hold wins over a new byte.
  assign load = begin_transmission
             && (state == E_IDLE || (state == E_HOLD && !slave_select));

  // The counter is held clear outside the shift state, and the eighth rise
  // stops it so SCLK parks high.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sclk_int   <= 1'b1;
      sclk_prev  <= 1'b1;
      half_count <= '0;
    end
    else
    begin
      sclk_prev <= sclk_int;
      if (state != E_SHIFT || last_rise)
        half_count <= '0;
      else if (half_count >= div)
      begin
        sclk_int   <= !sclk_int;
        half_count <= '0;
      end
      else
        half_count <= half_count + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state            <= E_IDLE;
      mosi             <= 1'b1;
      end_transmission <= 1'b0;
      bit_count        <= '0;
    end
    else
    begin
      end_transmission <= 1'b0;
      case (state)
        E_SHIFT:
          if (sclk_fall)
            mosi <= shift_reg[7];
          else if (sclk_rise)
          begin
            bit_count <= bit_count + 1'b1;
            if (last_rise)
            begin
              state            <= E_HOLD;
              end_transmission <= 1'b1;
            end
          end
        E_HOLD:
          if (slave_select)
          begin
            state <= E_IDLE;
            mosi  <= 1'b1;
          end
          else if (load)
          begin
            state     <= E_SHIFT;
            bit_count <= '0;
          end
        default:
          if (load)
          begin
            state     <= E_SHIFT;
            bit_count <= '0;
          end
      endcase
    end
  end

  // MISO enters at the bottom on each rising edge, most significant bit first.
  always_ff @(posedge clk)
  begin
    if (load)
      shift_reg <= send_data;
    else if (state == E_SHIFT && sclk_rise)
      shift_reg <= {shift_reg[6:0], miso};
    if (last_rise)
      received_data <= {shift_reg[6:0], miso};
  end

endmodule

`default_nettype wire

//--- rtl/spi_master_pkg.sv
`default_nettype none

`include "spi_master_params.svh"

package spi_master_pkg;

  localparam int SPI_IDX_W = $clog2(`SPI_BUF_DEPTH);
  // Counts carry one bit more than indices, so a full buffer differs from an empty one.
  localparam int SPI_CNT_W = SPI_IDX_W + 1;

  typedef logic [7:0] spi_byte_t;

  typedef enum logic [`SPI_ADDR_W-1:0] {
    CTRL   = 0,
    DIV    = 1,
    LEN    = 2,
    TXD    = 3,
    RXD    = 4,
    STATUS = 5
  } spi_reg_addr_e;

  typedef struct packed {
    logic [`SPI_DIV_W-1:0] div;
    logic [3:0]            len;
  } spi_cfg_t;

  typedef struct packed {
    logic sclk;
    logic mosi;
    logic ss_n;
  } spi_pins_t;

  typedef struct packed {
    logic busy;
    logic done_pulse;
  } spi_frame_status_t;

endpackage

`default_nettype wire

//--- rtl/spi_master_params.svh
`ifndef SPI_MASTER_PARAMS_SVH
`define SPI_MASTER_PARAMS_SVH

// Bytes held by each frame buffer, which is also the longest frame.
`define SPI_BUF_DEPTH 8

// Host register address width.
`define SPI_ADDR_W 3

// SCLK half-period divider width. SCLK toggles every div+1 clock cycles.
`define SPI_DIV_W 12

`endif
